// ==== all.f ====
+incdir+verilog
verilog/resp_pkg.sv
verilog/packet_disassembler.sv
verilog/resp_arbiter.sv
verilog/resp_path_top.sv
tb/resp_path_checker.sv
tb/resp_path_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the response path testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM=resp_path_sim

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f all.f --top-module resp_path_tb -Mdir "$BUILD_DIR" -o "$SIM"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# allow more than one assertion error so the testbench can report its verdict
output=$("./$BUILD_DIR/$SIM" +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q -x -F ">>> PASS"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1

// ==== tb/resp_path_checker.sv ====
`include "resp_defs.svh"

module resp_path_checker (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`NUM_SOURCES-1:0] in_val,
  input  logic [`NUM_SOURCES-1:0] in_rdy,
  input  resp_pkg::resp_t         in_msg_0,
  input  resp_pkg::resp_t         in_msg_1,
  input  resp_pkg::resp_t         in_msg_2,
  input  logic                    out_val,
  input  logic                    out_rdy,
  input  resp_pkg::packet_t       out_msg
);

  timeunit 1ns;
  timeprecision 1ps;

  resp_pkg::resp_t         in_msg [`NUM_SOURCES];

  // last response accepted from each source
  resp_pkg::resp_t         held_resp [`NUM_SOURCES];

  // chunks of the current packet already seen on the output, per source
  resp_pkg::chunk_idx_t    sent_cnt [`NUM_SOURCES];

  // a source is pending from its accept until its fourth chunk leaves
  logic [`NUM_SOURCES-1:0] pending;

  // cycle of the accept, so the age of two pending packets can be compared
  int unsigned             stamp [`NUM_SOURCES];
  int unsigned             cycle;

  // cycle at which the last packet ended and the output became free
  int unsigned             free_stamp;

  // a packet has started on the output and has not ended yet
  logic                    pkt_active;
  resp_pkg::src_addr_t     pkt_src;

  // set once any source has offered a response
  logic                    seen_offer;

  resp_pkg::src_addr_t     out_addr;
  resp_pkg::chunk_t        out_data;
  resp_pkg::chunk_t        exp_data;
  logic                    addr_ok;
  logic                    prio_bad;

  // each assertion counts its own failures and fail_count holds their sum
  int fails_idle      = 0;
  int fails_addr      = 0;
  int fails_stall     = 0;
  int fails_content   = 0;
  int fails_interleave = 0;
  int fails_prio      = 0;
  int fails_extra     = 0;
  int fail_count;

  assign in_msg[0] = in_msg_0;
  assign in_msg[1] = in_msg_1;
  assign in_msg[2] = in_msg_2;

  assign out_addr = out_msg[`SRC_ADDR_NBITS+`CHUNK_NBITS-1 -: `SRC_ADDR_NBITS];
  assign out_data = out_msg[`CHUNK_NBITS-1:0];
  assign addr_ok  = (int'(out_addr) < `NUM_SOURCES);

  always_comb begin : expect_calc
    resp_pkg::resp_t word;
    word     = '0;
    exp_data = '0;
    prio_bad = 1'b0;
    if (addr_ok) begin
      // the chunk due next is moved down to the bottom of the word
      word = held_resp[out_addr] >>
             (`CHUNK_NBITS * (`CHUNKS_PER_RESP - 1 - int'(sent_cnt[out_addr])));
      exp_data = word[`CHUNK_NBITS-1:0];
      // a lower source that was already waiting when this one could take
      // the free output should have won
      for (int k = 0; k < `NUM_SOURCES; k++) begin
        if (k < int'(out_addr) && pending[k] &&
            (stamp[k] <= stamp[out_addr] || stamp[k] <= free_stamp)) begin
          prio_bad = 1'b1;
        end
      end
    end
  end

  always_comb begin
    fail_count = fails_idle + fails_addr + fails_stall + fails_content +
                 fails_interleave + fails_prio + fails_extra;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending    <= '0;
      pkt_active <= 1'b0;
      pkt_src    <= '0;
      seen_offer <= 1'b0;
      cycle      <= 0;
      free_stamp <= 0;
      for (int k = 0; k < `NUM_SOURCES; k++) begin
        sent_cnt[k] <= '0;
        stamp[k]    <= 0;
      end
    end else begin
      cycle <= cycle + 1;
      if (in_val != '0) begin
        seen_offer <= 1'b1;
      end
      if (out_val && out_rdy && addr_ok) begin
        if (int'(sent_cnt[out_addr]) == `CHUNKS_PER_RESP - 1) begin
          sent_cnt[out_addr] <= '0;
          pending[out_addr]  <= 1'b0;
          pkt_active         <= 1'b0;
          free_stamp         <= cycle;
        end else begin
          sent_cnt[out_addr] <= sent_cnt[out_addr] + resp_pkg::chunk_idx_t'(1);
          pkt_active         <= 1'b1;
          pkt_src            <= out_addr;
        end
      end
      // a pending bit set by an accept here overrides a clear from the output update above
      for (int k = 0; k < `NUM_SOURCES; k++) begin
        if (in_val[k] && in_rdy[k]) begin
          held_resp[k] <= in_msg[k];
          pending[k]   <= 1'b1;
          stamp[k]     <= cycle;
        end
      end
    end
  end

  a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
    !seen_offer |-> (!out_val && in_rdy == '1))
    else begin
      fails_idle = fails_idle + 1;
      $error("** Error t=%0t out_val/in_rdy after reset: got %b/%b expected 0/%b",
             $time, $sampled(out_val), $sampled(in_rdy), {`NUM_SOURCES{1'b1}});
    end

  a_addr_range: assert property (@(posedge clk) disable iff (reset)
    out_val |-> addr_ok)
    else begin
      fails_addr = fails_addr + 1;
      $error("** Error t=%0t out_msg address: got %0d expected below %0d",
             $time, $sampled(out_addr), `NUM_SOURCES);
    end

  // valid must follow ready, otherwise a chunk could be lost downstream
  a_val_needs_rdy: assert property (@(posedge clk) disable iff (reset)
    out_val |-> out_rdy)
    else begin
      fails_stall = fails_stall + 1;
      $error("** Error t=%0t out_val under back-pressure: got 1 expected 0", $time);
    end

  a_content: assert property (@(posedge clk) disable iff (reset)
    (out_val && out_rdy && addr_ok) |-> (out_data == exp_data))
    else begin
      fails_content = fails_content + 1;
      $error("** Error t=%0t out_msg chunk: got %h expected %h",
             $time, $sampled(out_data), $sampled(exp_data));
    end

  a_no_interleave: assert property (@(posedge clk) disable iff (reset)
    (out_val && out_rdy && pkt_active) |-> (out_addr == pkt_src))
    else begin
      fails_interleave = fails_interleave + 1;
      $error("** Error t=%0t out_msg address inside packet: got %0d expected %0d",
             $time, $sampled(out_addr), $sampled(pkt_src));
    end

  a_priority: assert property (@(posedge clk) disable iff (reset)
    (out_val && out_rdy && !pkt_active && addr_ok) |-> !prio_bad)
    else begin
      fails_prio = fails_prio + 1;
      $error("source %0d started a packet while a lower source was waiting for the output",
             $sampled(out_addr));
    end

  // nothing may come out of a source that has no response left to send
  a_only_pending: assert property (@(posedge clk) disable iff (reset)
    (out_val && out_rdy && addr_ok) |-> pending[out_addr])
    else begin
      fails_extra = fails_extra + 1;
      $error("source %0d sent a chunk with no response accepted", $sampled(out_addr));
    end

endmodule

// ==== tb/resp_path_tb.sv ====
`include "resp_defs.svh"

module resp_path_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 20;

  // longest run of cycles that out_rdy is held low
  localparam int MAX_STALL = 3;

  // responses over all tests, the watchdog is sized from this
  localparam int TOTAL_RESP = 3 + 6 + 3 * 12;
  localparam int WATCHDOG_CYCLES = TOTAL_RESP * `CHUNKS_PER_RESP * (MAX_STALL + 1) +
                                   TOTAL_RESP * 8 + 200;

  logic                    clk;
  logic                    reset;
  logic [`NUM_SOURCES-1:0] in_val;
  logic [`NUM_SOURCES-1:0] in_rdy;
  resp_pkg::resp_t         in_msg [`NUM_SOURCES];
  logic                    out_val;
  logic                    out_rdy;
  resp_pkg::packet_t       out_msg;
  resp_pkg::src_addr_t     out_addr;

  logic [31:0] rng_state = 32'h7c44;
  int          stall_run = 0;

  // running totals over the whole run, per source
  int accepted [`NUM_SOURCES]   = '{default: 0};
  int out_chunks [`NUM_SOURCES] = '{default: 0};

  int tests_run    = 0;
  int tests_failed = 0;
  int total_errors = 0;

  resp_path_top i_resp_path_top (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_msg_0 (in_msg[0]),
    .in_msg_1 (in_msg[1]),
    .in_msg_2 (in_msg[2]),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_msg  (out_msg)
  );

  bind resp_path_top resp_path_checker i_resp_path_checker (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_msg_0 (in_msg_0),
    .in_msg_1 (in_msg_1),
    .in_msg_2 (in_msg_2),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_msg  (out_msg)
  );

  assign out_addr = out_msg[`SRC_ADDR_NBITS+`CHUNK_NBITS-1 -: `SRC_ADDR_NBITS];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // counts the chunks that leave per source
  always @(posedge clk) begin
    if (!reset && out_val && out_rdy && int'(out_addr) < `NUM_SOURCES) begin
      out_chunks[out_addr]++;
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // random back-pressure, never longer than MAX_STALL cycles in a row
  task automatic drive_ready(input bit stall);
    logic [31:0] r;
    r = next_random();
    if (stall && stall_run < MAX_STALL && r[17:16] < 2'd2) begin
      out_rdy = 1'b0;
      stall_run++;
    end else begin
      out_rdy = 1'b1;
      stall_run = 0;
    end
  endtask

  // offers n0, n1 and n2 responses, waits until all of them have left,
  // then compares the per-source counts and prints the test line
  task automatic run_test(input string name, input int n0, input int n1, input int n2,
                          input bit aligned);
    int                      remaining [`NUM_SOURCES];
    logic [`NUM_SOURCES-1:0] taken;
    int                      left_total;
    int                      expected_total;
    int                      seen_total;
    int                      fails_before;
    int                      errors;
    logic [31:0]             r;
    remaining[0] = n0;
    remaining[1] = n1;
    remaining[2] = n2;
    taken        = '0;
    errors       = 0;
    fails_before = i_resp_path_top.i_resp_path_checker.fail_count;
    forever begin
      @(negedge clk);
      for (int k = 0; k < `NUM_SOURCES; k++) begin
        // the transfer seen at the last falling edge has now happened
        if (taken[k]) begin
          in_val[k] = 1'b0;
          remaining[k]--;
          accepted[k]++;
        end
        r = next_random();
        if (!in_val[k] && remaining[k] > 0 && (aligned || r[20])) begin
          in_val[k] = 1'b1;
          in_msg[k] = next_random();
        end
      end
      drive_ready(1'b1);
      // in_rdy follows only the disassembler state, stable up to the next edge
      taken = in_val & in_rdy;
      left_total     = 0;
      expected_total = 0;
      seen_total     = 0;
      for (int k = 0; k < `NUM_SOURCES; k++) begin
        left_total     += remaining[k];
        expected_total += `CHUNKS_PER_RESP * accepted[k];
        seen_total     += out_chunks[k];
      end
      if (left_total == 0 && seen_total >= expected_total) begin
        break;
      end
    end
    // a few quiet cycles so late extra chunks would still be counted
    repeat (3) begin
      @(negedge clk);
      drive_ready(1'b0);
    end
    for (int k = 0; k < `NUM_SOURCES; k++) begin
      assert (out_chunks[k] == `CHUNKS_PER_RESP * accepted[k]) else begin
        $display("** Error t=%0t out chunks of source %0d: got %0d expected %0d",
                 $time, k, out_chunks[k], `CHUNKS_PER_RESP * accepted[k]);
        errors++;
      end
    end
    errors += i_resp_path_top.i_resp_path_checker.fail_count - fails_before;
    tests_run++;
    total_errors += errors;
    if (errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d responses, %0d errors", name, n0 + n1 + n2, errors);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    reset   = 1'b1;
    in_val  = '0;
    out_rdy = 1'b0;
    for (int k = 0; k < `NUM_SOURCES; k++) begin
      in_msg[k] = '0;
    end
    repeat (3) @(negedge clk);
    reset = 1'b0;

    run_test("reset_idle", 0, 0, 0, 1'b0);
    // all three offered in one cycle, packets must leave as 0, 1, 2
    run_test("priority", 1, 1, 1, 1'b1);
    run_test("single_source", 0, 6, 0, 1'b0);
    run_test("random_mix", 12, 12, 12, 1'b0);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/packet_disassembler.sv ====
`include "resp_defs.svh"

module packet_disassembler (
  input  logic             clk,
  input  logic             reset,

  // response stream from one source
  input  logic             resp_val,
  output logic             resp_rdy,
  input  resp_pkg::resp_t  resp_msg,

  // chunk stream toward the arbiter
  output logic             chunk_val,
  input  logic             chunk_rdy,
  output resp_pkg::chunk_t chunk_msg
);

  resp_pkg::disasm_state_e state;

  // holds the response, the chunk on its way out always sits at the top
  resp_pkg::resp_t         shift_reg;

  // number of chunks of the current packet that have already transferred
  resp_pkg::chunk_idx_t    chunk_cnt;

  logic                    resp_xfer;
  logic                    chunk_xfer;
  logic                    last_chunk;

  // a new response is only taken while nothing is being sent
  assign resp_rdy = (state == resp_pkg::DISASM_IDLE);

  // valid stays up for the whole packet, whatever the back-pressure does
  assign chunk_val = (state == resp_pkg::DISASM_SENDING);

  // most significant chunk goes first, so the top slice is presented
  assign chunk_msg = shift_reg[`RESP_NBITS-1 -: `CHUNK_NBITS];

  assign resp_xfer  = resp_val & resp_rdy;
  assign chunk_xfer = chunk_val & chunk_rdy;

  // the counter reaching the final index means this transfer ends the packet
  assign last_chunk = (chunk_cnt == resp_pkg::chunk_idx_t'(`CHUNKS_PER_RESP - 1));

  // state and chunk counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= resp_pkg::DISASM_IDLE;
      chunk_cnt <= '0;
    end else begin
      case (state)
        resp_pkg::DISASM_IDLE: begin
          // the first chunk becomes valid on the cycle after the accept
          if (resp_xfer) begin
            state     <= resp_pkg::DISASM_SENDING;
            chunk_cnt <= '0;
          end
        end
        resp_pkg::DISASM_SENDING: begin
          if (chunk_xfer) begin
            chunk_cnt <= chunk_cnt + resp_pkg::chunk_idx_t'(1);
            // going back to idle drops valid for at least one cycle,
            // which is the gap the arbiter relies on to move its grant
            if (last_chunk) begin
              state <= resp_pkg::DISASM_IDLE;
            end
          end
        end
        default: begin
          state <= resp_pkg::DISASM_IDLE;
        end
      endcase
    end
  end

  // response shift register
  always_ff @(posedge clk) begin
    if (resp_xfer) begin
      shift_reg <= resp_msg;
    end else if (chunk_xfer) begin
      // the next chunk moves into the top slice right after a transfer,
      // so consecutive chunks go out with no idle cycle in between
      shift_reg <= shift_reg << `CHUNK_NBITS;
    end
  end

endmodule

// ==== verilog/resp_arbiter.sv ====
`include "resp_defs.svh"

module resp_arbiter #(
  parameter int ninputs = 2
) (
  input  logic               clk,
  input  logic               reset,

  // chunk streams from the disassemblers, one bit or entry per input
  input  logic [ninputs-1:0] istream_val,
  output logic [ninputs-1:0] istream_rdy,
  input  resp_pkg::chunk_t   istream_msg [ninputs],

  // prefixed chunk stream toward the SPI wrapper
  output logic               ostream_val,
  input  logic               ostream_rdy,
  output resp_pkg::packet_t  ostream_msg
);

  // input that owns the output in this cycle
  resp_pkg::src_addr_t grant;

  // grant of the previous cycle, used to keep a packet together
  resp_pkg::src_addr_t last_grant;

  // lowest-index valid input, or 0 when no input is valid
  resp_pkg::src_addr_t prio_grant;

  // each link of the chain passes on its own index when valid,
  // otherwise whatever the higher indices decided
  resp_pkg::src_addr_t prio_chain [ninputs+1];

  assign prio_chain[ninputs] = '0;

  for (genvar i = 0; i < ninputs; i++) begin : g_prio
    assign prio_chain[i] = istream_val[i] ? resp_pkg::src_addr_t'(i) : prio_chain[i+1];
  end

  // index 0 sits at the head of the chain and so has the highest priority
  assign prio_grant = prio_chain[0];

  // a disassembler keeps valid high across its whole packet, so the
  // grant only moves once the previous owner has dropped valid
  always_comb begin
    if (istream_val[last_grant]) begin
      grant = last_grant;
    end else begin
      grant = prio_grant;
    end
  end

  // only the granted input sees ready, and only while the wrapper is ready
  for (genvar i = 0; i < ninputs; i++) begin : g_rdy
    assign istream_rdy[i] = (grant == resp_pkg::src_addr_t'(i)) & ostream_rdy;
  end

  // valid goes out together with ready, so it stays low under back-pressure
  assign ostream_val = istream_val[grant] & istream_rdy[grant];

  // the address of the granted input is put in front of its chunk
  assign ostream_msg = {grant, istream_msg[grant]};

  // grant history, updated every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= '0;
    end else begin
      last_grant <= grant;
    end
  end

endmodule

// ==== verilog/resp_defs.svh ====
`ifndef RESP_DEFS_SVH
`define RESP_DEFS_SVH

// widths and counts shared by the response return path

// one full response from an accelerator unit
`define RESP_NBITS 32

// one SPI transfer, the width the wrapper moves per packet
`define CHUNK_NBITS 8

// number of chunks a response is split into
`define CHUNKS_PER_RESP 4

// number of response sources feeding the arbiter
`define NUM_SOURCES 3

// width of the source address put in front of every chunk
`define SRC_ADDR_NBITS 2

`endif

// ==== verilog/resp_path_top.sv ====
`include "resp_defs.svh"

module resp_path_top (
  input  logic                    clk,
  input  logic                    reset,

  // response streams from the three sources
  input  logic [`NUM_SOURCES-1:0] in_val,
  output logic [`NUM_SOURCES-1:0] in_rdy,
  input  resp_pkg::resp_t         in_msg_0,
  input  resp_pkg::resp_t         in_msg_1,
  input  resp_pkg::resp_t         in_msg_2,

  // prefixed chunk stream toward the SPI wrapper
  output logic                    out_val,
  input  logic                    out_rdy,
  output resp_pkg::packet_t       out_msg
);

  // per-source response messages gathered into one array for the generate
  resp_pkg::resp_t         in_msg [`NUM_SOURCES];

  // chunk streams between the disassemblers and the arbiter
  logic [`NUM_SOURCES-1:0] chunk_val;
  logic [`NUM_SOURCES-1:0] chunk_rdy;
  resp_pkg::chunk_t        chunk_msg [`NUM_SOURCES];

  assign in_msg[0] = in_msg_0;
  assign in_msg[1] = in_msg_1;
  assign in_msg[2] = in_msg_2;

  // one disassembler per source, each turns a response into four chunks
  for (genvar k = 0; k < `NUM_SOURCES; k++) begin : g_disasm
    packet_disassembler i_packet_disassembler (
      .clk       (clk),
      .reset     (reset),
      .resp_val  (in_val[k]),
      .resp_rdy  (in_rdy[k]),
      .resp_msg  (in_msg[k]),
      .chunk_val (chunk_val[k]),
      .chunk_rdy (chunk_rdy[k]),
      .chunk_msg (chunk_msg[k])
    );
  end

  // the arbiter adds no latency, the disassembler index becomes the
  // address prefix on the output
  resp_arbiter #(
    .ninputs (`NUM_SOURCES)
  ) i_resp_arbiter (
    .clk         (clk),
    .reset       (reset),
    .istream_val (chunk_val),
    .istream_rdy (chunk_rdy),
    .istream_msg (chunk_msg),
    .ostream_val (out_val),
    .ostream_rdy (out_rdy),
    .ostream_msg (out_msg)
  );

endmodule

// ==== verilog/resp_pkg.sv ====
`include "resp_defs.svh"

package resp_pkg;

  // a full response as handed over by a source
  typedef logic [`RESP_NBITS-1:0] resp_t;

  // the data part of one SPI transfer
  typedef logic [`CHUNK_NBITS-1:0] chunk_t;

  // the source address that prefixes each chunk on the output
  typedef logic [`SRC_ADDR_NBITS-1:0] src_addr_t;

  // counts the chunks already sent within one packet
  typedef logic [1:0] chunk_idx_t;

  // what the wrapper receives, address in the top bits and chunk below
  typedef logic [`SRC_ADDR_NBITS+`CHUNK_NBITS-1:0] packet_t;

  // idle waits for a response, sending streams its chunks out
  typedef enum logic {
    DISASM_IDLE    = 1'b0,
    DISASM_SENDING = 1'b1
  } disasm_state_e;

endpackage
